// ==== SdSpi_defines.svh ====
/*
	SD-card SPI host controller, build constants
	bus widths, block address, control bit layout and divider setup
*/

`ifndef SDSPI_DEFINES_SVH
`define SDSPI_DEFINES_SVH

// bus widths
`define SDSPI_DATA_W 64
`define SDSPI_ADDR_W 32
`define SDSPI_OPM_W 5

// block address, compared with address bits 15:4
`define SDSPI_SELF_ADDR 12'h050

// control register bits
`define SDSPI_CTRL_CS 0
`define SDSPI_CTRL_XMIT1 1
`define SDSPI_CTRL_XMIT8 5
// divider byte sits in the top byte of the control word
`define SDSPI_CTRL_DIV_LSB 24

// divider count is {divider byte, low nibble}
`define SDSPI_DIV_W 14
`define SDSPI_DIV_LSB 4'hA

// bytes moved by one burst
`define SDSPI_BURST_BYTES 8

`endif

// ==== SdSpiPkg.sv ====
/*
	SD-card SPI host controller, shared types
	bus response status, opcode bit positions and register index
*/

package SdSpiPkg;

	// response status on mmioOK
	// READY when idle, OK once serviced, HOLD while the master must wait
	typedef enum logic [1:0]
	{
		statusReady = 2'b00,
		statusOk    = 2'b01,
		statusHold  = 2'b10
	} mmioStatusT;

	// bit positions inside mmioOpm
	// bit 3 asks for a load, bit 4 for a store
	typedef enum logic [2:0]
	{
		opmReadBit  = 3'd3,
		opmWriteBit = 3'd4
	} mmioOpmBitT;

	// register index taken from address bits 3:2
	// the fourth code is unused and reads as zero
	typedef enum logic [1:0]
	{
		regCtrl  = 2'b00,
		regExch  = 2'b01,
		regQueue = 2'b10
	} spiRegSelT;

endpackage

// ==== SdSpiDecode.sv ====
/*
	SD-card SPI host controller, request decode
	registers the bus request, matches the block address and splits it
	into register index, read and write enables
*/

`timescale 1ns/10ps

`include "SdSpi_defines.svh"

module SdSpiDecode
	import SdSpiPkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`SDSPI_DATA_W-1:0]  mmioInData,
	input  logic [`SDSPI_ADDR_W-1:0]  mmioAddr,
	input  logic [`SDSPI_OPM_W-1:0]   mmioOpm,
	output spiRegSelT                 regSel,
	output logic                      readEn,
	output logic                      writeEn,
	output logic [`SDSPI_DATA_W-1:0]  writeData
);

	// request copy, one cycle behind the bus
	logic [`SDSPI_DATA_W-1:0] dataReg;
	logic [`SDSPI_ADDR_W-1:0] addrReg;
	logic [`SDSPI_OPM_W-1:0] opmReg;
	logic selfSel;

	always_ff @(posedge clock)
	begin
		dataReg <= mmioInData;
		addrReg <= mmioAddr;
		// only the opcode needs a clean idle value
		if (reset)
			opmReg <= '0;
		else
			opmReg <= mmioOpm;
	end

	// low region, then our 16-byte slot inside it
	assign selfSel = (addrReg[27:16] == 12'h000) && (addrReg[15:4] == `SDSPI_SELF_ADDR);

	// word index within the slot
	assign regSel = spiRegSelT'(addrReg[3:2]);

	assign readEn = opmReg[opmReadBit] && selfSel;
	assign writeEn = opmReg[opmWriteBit] && selfSel;
	assign writeData = dataReg;

	// master never issues load and store at once to this block
	assert property (@(posedge clock) disable iff (reset) !(readEn && writeEn))
		else $error("SdSpiDecode: read and write requested together");

endmodule

// ==== SdSpiEngine.sv ====
/*
	SD-card SPI host controller, shift engine
	control register, clock divider, bit and byte counters,
	exchange and queue shift registers, SPI pin drive
*/

`timescale 1ns/10ps

`include "SdSpi_defines.svh"

module SdSpiEngine
	import SdSpiPkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  spiRegSelT                 regSel,
	input  logic                      readEn,
	input  logic                      writeEn,
	input  logic [`SDSPI_DATA_W-1:0]  writeData,
	input  logic                      latchedWrite,
	input  logic                      spiMiso,
	output logic                      spiSclk,
	output logic                      spiMosi,
	output logic                      spiCs,
	output logic                      busy,
	output logic [31:0]               ctrlValue,
	output logic [7:0]                rxByte,
	output logic [`SDSPI_DATA_W-1:0]  recvQueue
);

	logic [31:0] ctrlReg;
	logic [`SDSPI_DIV_W-1:0] divCnt;
	logic [`SDSPI_DIV_W-1:0] divRst;
	logic [`SDSPI_DIV_W-1:0] halfCnt;
	logic [3:0] bitCnt;
	logic [3:0] byteCnt;
	logic xmitDeb;
	logic misoSync1;
	logic misoSync2;
	logic [7:0] txShift;
	logic [7:0] rxShift;
	logic [`SDSPI_DATA_W-1:0] sendQ;
	logic [`SDSPI_DATA_W-1:0] recvQ;
	logic boundary;
	logic byteStep;
	logic sclkRise;
	logic freshWrite;
	logic ctrlAccept;
	logic exchAccept;
	logic queueAccept;

	// bit period is divRst+1 cycles, 16*div+11
	assign divRst = {2'b00, ctrlReg[`SDSPI_CTRL_DIV_LSB +: 8], `SDSPI_DIV_LSB};
	assign halfCnt = divRst >> 1;

	// bit boundary, sclk low and next mosi bit
	assign boundary = (divCnt == '0) && (bitCnt != 4'd0);
	// burst step once the previous byte has fully drained
	assign byteStep = (divCnt == '0) && (bitCnt == 4'd0) && (byteCnt != 4'd0);
	// mid-bit, sclk high and miso capture
	assign sclkRise = (divCnt != '0) && (divCnt == halfCnt);

	// divider still running covers the tail after the last bit
	assign busy = (bitCnt != 4'd0) || (byteCnt != 4'd0) || (divCnt != '0);

	// a held write is taken once, before the result latch closes
	assign freshWrite = writeEn && !latchedWrite;
	assign ctrlAccept = freshWrite && (regSel == regCtrl) && !busy && !xmitDeb;
	assign exchAccept = freshWrite && (regSel == regExch) && !busy;
	assign queueAccept = freshWrite && (regSel == regQueue);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ctrlReg <= '0;
			divCnt <= '0;
			bitCnt <= 4'd0;
			byteCnt <= 4'd0;
			xmitDeb <= 1'b0;
			spiSclk <= 1'b0;
			spiMosi <= 1'b1;
		end
		else
		begin
			if (divCnt != '0)
			begin
				divCnt <= divCnt - 1'b1;
				if (sclkRise)
					spiSclk <= 1'b1;
			end
			else
			begin
				// also parks sclk low when idle
				spiSclk <= 1'b0;
				if (boundary)
				begin
					spiMosi <= txShift[7];
					divCnt <= divRst;
					bitCnt <= bitCnt - 1'b1;
				end
				else if (byteStep)
				begin
					// last step only flushes the final byte into recvQ
					byteCnt <= byteCnt - 1'b1;
					bitCnt <= (byteCnt != 4'd1) ? 4'd8 : 4'd0;
				end
			end

			// control write, optionally launching a transfer
			if (ctrlAccept)
			begin
				ctrlReg <= writeData[31:0];
				if (writeData[`SDSPI_CTRL_XMIT1])
				begin
					bitCnt <= 4'd8;
					xmitDeb <= 1'b1;
				end
				else if (writeData[`SDSPI_CTRL_XMIT8])
				begin
					// one extra step to push the last byte
					byteCnt <= 4'(`SDSPI_BURST_BYTES + 1);
					xmitDeb <= 1'b1;
				end
			end
			else if (readEn || !writeEn)
			begin
				// start strobe ends with a read or a dropped opcode
				xmitDeb <= 1'b0;
			end
		end
	end

	// data path, no reset needed
	always_ff @(posedge clock)
	begin
		// two-stage miso input
		misoSync1 <= spiMiso;
		misoSync2 <= misoSync1;

		if (boundary)
			txShift <= {txShift[6:0], 1'b0};
		else if (byteStep)
			txShift <= sendQ[7:0];
		else if (exchAccept)
			txShift <= writeData[7:0];

		// sampling at the rise reads the pin two cycles earlier,
		// still inside the bit the slave has been holding
		if (sclkRise)
			rxShift <= {rxShift[6:0], misoSync2};

		if (byteStep)
		begin
			// send low byte first, refill with 0xFF
			sendQ <= {8'hFF, sendQ[`SDSPI_DATA_W-1:8]};
			// received bytes enter from the top
			recvQ <= {rxShift, recvQ[`SDSPI_DATA_W-1:8]};
		end
		else if (queueAccept)
		begin
			sendQ <= writeData;
		end
	end

	assign spiCs = ctrlReg[`SDSPI_CTRL_CS];
	assign ctrlValue = ctrlReg;
	assign rxByte = rxShift;
	assign recvQueue = recvQ;

	// one byte is eight bits
	assert property (@(posedge clock) disable iff (reset) bitCnt <= 4'd8)
		else $error("SdSpiEngine: bit count above 8");

	// burst plus the flush step
	assert property (@(posedge clock) disable iff (reset)
		byteCnt <= 4'(`SDSPI_BURST_BYTES + 1))
		else $error("SdSpiEngine: byte count above burst length");

endmodule

// ==== SdSpiResult.sv ====
/*
	SD-card SPI host controller, response path
	selects read data, derives OK/HOLD/READY with write-latch
	tracking and registers the response onto the bus
*/

`timescale 1ns/10ps

`include "SdSpi_defines.svh"

module SdSpiResult
	import SdSpiPkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  spiRegSelT                 regSel,
	input  logic                      readEn,
	input  logic                      writeEn,
	input  logic                      busy,
	input  logic [31:0]               ctrlValue,
	input  logic [7:0]                rxByte,
	input  logic [`SDSPI_DATA_W-1:0]  recvQueue,
	output logic                      latchedWrite,
	output logic [`SDSPI_DATA_W-1:0]  mmioOutData,
	output mmioStatusT                mmioOK
);

	logic [31:0] ctrlShown;
	logic [`SDSPI_DATA_W-1:0] readData;
	logic blocked;
	logic latchNext;
	mmioStatusT status;

	// bit 1 reads back as the busy flag
	always_comb
	begin
		ctrlShown = ctrlValue;
		ctrlShown[`SDSPI_CTRL_XMIT1] = busy;
	end

	always_comb
	begin
		case (regSel)
			regCtrl:  readData = {{(`SDSPI_DATA_W-32){1'b0}}, ctrlShown};
			regExch:  readData = {{(`SDSPI_DATA_W-8){1'b0}}, rxByte};
			regQueue: readData = recvQueue;
			default:  readData = '0;
		endcase
	end

	// control and exchange wait for the shifter, queue never does
	assign blocked = busy && ((regSel == regCtrl) || (regSel == regExch));

	// latch opens with the accepted write, closes when the opcode drops
	assign latchNext = writeEn && (latchedWrite || !blocked);

	always_comb
	begin
		status = statusReady;
		if (writeEn)
			status = latchedWrite ? statusOk : statusHold;
		else if (readEn)
			status = (busy && (regSel == regExch)) ? statusHold : statusOk;
	end

	always_ff @(posedge clock)
	begin
		mmioOutData <= readData;
		if (reset)
		begin
			latchedWrite <= 1'b0;
			mmioOK <= statusReady;
		end
		else
		begin
			latchedWrite <= latchNext;
			mmioOK <= status;
		end
	end

endmodule

// ==== SdSpiTop.sv ====
/*
	SD-card SPI host controller, top level
	request decode, SPI shift engine and response path on the MMIO bus
*/

`timescale 1ns/10ps

`include "SdSpi_defines.svh"

module SdSpiTop
	import SdSpiPkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`SDSPI_DATA_W-1:0]  mmioInData,
	output logic [`SDSPI_DATA_W-1:0]  mmioOutData,
	input  logic [`SDSPI_ADDR_W-1:0]  mmioAddr,
	input  logic [`SDSPI_OPM_W-1:0]   mmioOpm,
	output mmioStatusT                mmioOK,
	output logic                      spiSclk,
	output logic                      spiMosi,
	output logic                      spiCs,
	input  logic                      spiMiso
);

	// decoded request
	spiRegSelT regSel;
	logic readEn;
	logic writeEn;
	logic [`SDSPI_DATA_W-1:0] writeData;

	// engine state seen by the response path
	logic busy;
	logic [31:0] ctrlValue;
	logic [7:0] rxByte;
	logic [`SDSPI_DATA_W-1:0] recvQueue;

	// write accepted, back to the engine
	logic latchedWrite;

	SdSpiDecode decode
	(
		.clock(clock),
		.reset(reset),
		.mmioInData(mmioInData),
		.mmioAddr(mmioAddr),
		.mmioOpm(mmioOpm),
		.regSel(regSel),
		.readEn(readEn),
		.writeEn(writeEn),
		.writeData(writeData)
	);

	SdSpiEngine engine
	(
		.clock(clock),
		.reset(reset),
		.regSel(regSel),
		.readEn(readEn),
		.writeEn(writeEn),
		.writeData(writeData),
		.latchedWrite(latchedWrite),
		.spiMiso(spiMiso),
		.spiSclk(spiSclk),
		.spiMosi(spiMosi),
		.spiCs(spiCs),
		.busy(busy),
		.ctrlValue(ctrlValue),
		.rxByte(rxByte),
		.recvQueue(recvQueue)
	);

	SdSpiResult result
	(
		.clock(clock),
		.reset(reset),
		.regSel(regSel),
		.readEn(readEn),
		.writeEn(writeEn),
		.busy(busy),
		.ctrlValue(ctrlValue),
		.rxByte(rxByte),
		.recvQueue(recvQueue),
		.latchedWrite(latchedWrite),
		.mmioOutData(mmioOutData),
		.mmioOK(mmioOK)
	);

endmodule

// ==== SdSpiTb.sv ====
/*
	SD-card SPI host controller testbench
	table of bus accesses applied in a loop, SPI slave model fed by an
	LFSR, watchdog and error counts
*/

`timescale 1ns/10ps

`include "SdSpi_defines.svh"

module SdSpiTb
	import SdSpiPkg::*;
();

	localparam int clockPeriod = 4;
	// burst of eight bytes at the slowest divider in the table plus slack
	localparam int longestCycles = 8 * 8 * (16 * 2 + 11) + 100;
	localparam int maxRows = 32;
	// opcode bit 3 is a load and bit 4 a store
	localparam logic [`SDSPI_OPM_W-1:0] opmRead = 5'b01000;
	localparam logic [`SDSPI_OPM_W-1:0] opmWrite = 5'b10000;

	typedef enum int
	{
		kindRead,
		kindWrite,
		kindReadWait,
		kindWaitIdle,
		kindCs,
		kindMosi,
		kindPeriod
	} opKindT;

	logic clock;
	logic reset;
	logic [`SDSPI_DATA_W-1:0] mmioInData;
	logic [`SDSPI_DATA_W-1:0] mmioOutData;
	logic [`SDSPI_ADDR_W-1:0] mmioAddr;
	logic [`SDSPI_OPM_W-1:0] mmioOpm;
	mmioStatusT mmioOK;
	logic spiSclk;
	logic spiMosi;
	logic spiCs;
	logic spiMiso;

	// stimulus table with one row per access or check
	string rowName [maxRows];
	opKindT rowKind [maxRows];
	spiRegSelT rowReg [maxRows];
	logic [63:0] rowData [maxRows];
	logic [63:0] rowReply [maxRows];
	logic [63:0] rowExpect [maxRows];
	int rowLatency [maxRows];
	int rowCount = 0;

	// slave reply bytes in the order the transfers happen
	logic [7:0] replyStream [maxRows * 8];
	int streamLen = 0;
	logic tableReady = 1'b0;
	logic [15:0] lfsrState = 16'd36081;

	// slave observations
	logic [63:0] mosiCapture;
	int risePeriod;
	time lastRise;
	int bitPos;

	int errorCount = 0;
	int checkCount = 0;

	SdSpiTop DUT
	(
		.clock(clock),
		.reset(reset),
		.mmioInData(mmioInData),
		.mmioOutData(mmioOutData),
		.mmioAddr(mmioAddr),
		.mmioOpm(mmioOpm),
		.mmioOK(mmioOK),
		.spiSclk(spiSclk),
		.spiMosi(spiMosi),
		.spiCs(spiCs),
		.spiMiso(spiMiso)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	// taps x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at bit 0
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// eight steps with the first bit taken ending up as the MSB
	task automatic takeByte(output logic [7:0] value);
		value = 8'h00;
		repeat (8)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
	endtask

	// bits past the end of the stream idle high
	function automatic logic streamBit(input int position);
		if (position >= streamLen * 8)
			return 1'b1;
		return replyStream[position / 8][7 - position % 8];
	endfunction

	task automatic addRow(input string name, input opKindT kind, input spiRegSelT regIdx,
		input logic [63:0] data, input int replies, input logic [63:0] expected,
		input int latency);
		logic [7:0] oneByte;
		rowName[rowCount] = name;
		rowKind[rowCount] = kind;
		rowReg[rowCount] = regIdx;
		rowData[rowCount] = data;
		rowLatency[rowCount] = latency;
		rowReply[rowCount] = '0;
		for (int b = 0; b < replies; b++)
		begin
			takeByte(oneByte);
			// first byte received lands in the low byte
			rowReply[rowCount][8 * b +: 8] = oneByte;
			replyStream[streamLen] = oneByte;
			streamLen++;
		end
		// rows that collect slave bytes expect exactly those
		rowExpect[rowCount] = (replies > 0) ? rowReply[rowCount] : expected;
		rowCount++;
	endtask

	task automatic buildTable();
		addRow("reset ctrl read", kindRead, regCtrl, '0, 0, 64'h0, 2);
		addRow("cs write", kindWrite, regCtrl, 64'h1, 0, '0, 3);
		addRow("cs pin", kindCs, regCtrl, '0, 0, 64'h1, 0);
		addRow("cs read", kindRead, regCtrl, '0, 0, 64'h1, 2);
		addRow("exch write", kindWrite, regExch, 64'hA5, 0, '0, 3);
		addRow("single start", kindWrite, regCtrl, 64'h3, 0, '0, 3);
		addRow("busy read", kindRead, regCtrl, '0, 0, 64'h3, 2);
		addRow("exch hold read", kindReadWait, regExch, '0, 1, '0, 0);
		addRow("idle read", kindRead, regCtrl, '0, 0, 64'h1, 2);
		addRow("single mosi", kindMosi, regCtrl, '0, 0, 64'hA5, 0);
		addRow("queue write", kindWrite, regQueue, 64'hF00DCAFE12345678, 0, '0, 3);
		addRow("burst start", kindWrite, regCtrl, 64'h21, 0, '0, 3);
		addRow("burst idle", kindWaitIdle, regCtrl, '0, 0, '0, 0);
		addRow("queue read", kindRead, regQueue, '0, 8, '0, 2);
		// low byte first and each byte MSB first
		addRow("burst mosi", kindMosi, regCtrl, '0, 0, 64'h78563412FECA0DF0, 0);
		addRow("slow exch write", kindWrite, regExch, 64'h3C, 0, '0, 3);
		addRow("slow start", kindWrite, regCtrl, 64'h02000003, 0, '0, 3);
		addRow("slow exch read", kindReadWait, regExch, '0, 1, '0, 0);
		addRow("slow mosi", kindMosi, regCtrl, '0, 0, 64'h563412FECA0DF03C, 0);
		// divider byte 2
		addRow("bit period", kindPeriod, regCtrl, '0, 0, 16 * 2 + 11, 0);
	endtask

	task automatic reportMismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		errorCount++;
		$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
	endtask

	// one bus access holding the request until OK and then dropping the opcode
	task automatic access(input logic isWrite, input spiRegSelT regIdx,
		input logic [63:0] data, output logic [63:0] readBack, output int cycles,
		output logic sawHold);
		cycles = 0;
		sawHold = 1'b0;
		@(posedge clock);
		mmioAddr <= {16'h0000, `SDSPI_SELF_ADDR, regIdx, 2'b00};
		mmioInData <= data;
		mmioOpm <= isWrite ? opmWrite : opmRead;
		do
		begin
			@(posedge clock);
			cycles++;
			// status is registered and stable by the falling edge
			@(negedge clock);
			if (mmioOK == statusHold)
				sawHold = 1'b1;
		end
		while (mmioOK != statusOk);
		readBack = mmioOutData;
		@(posedge clock);
		mmioOpm <= '0;
		// let the write latch and status return to idle
		repeat (2) @(posedge clock);
	endtask

	// mode 0 SPI slave shifting one reply bit per rising sclk
	initial
	begin
		spiMiso = 1'b1;
		bitPos = 0;
		mosiCapture = '0;
		lastRise = 0;
		risePeriod = 0;
		wait (tableReady);
		// first reply bit goes out once the card is selected
		wait (spiCs === 1'b1);
		spiMiso = streamBit(0);
		forever
		begin
			@(posedge spiSclk);
			mosiCapture = {mosiCapture[62:0], spiMosi};
			risePeriod = int'(($time - lastRise) / clockPeriod);
			lastRise = $time;
			bitPos++;
			spiMiso <= streamBit(bitPos);
		end
	end

	// watchdog scaled by table length
	initial
	begin
		wait (tableReady);
		#(rowCount * longestCycles * clockPeriod + 2000);
		$display("error: watchdog expired, a bus access or transfer never completed");
		$display("%0d checks, %0d errors", checkCount, errorCount + 1);
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		logic [63:0] readBack;
		int cycles;
		logic sawHold;
		reset = 1'b1;
		mmioInData = '0;
		mmioAddr = '0;
		mmioOpm = '0;
		buildTable();
		tableReady = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		@(negedge clock);
		checkCount++;
		if (mmioOK !== statusReady)
			reportMismatch("reset status", statusReady, mmioOK);

		for (int i = 0; i < rowCount; i++)
		begin
			case (rowKind[i])
				kindRead, kindWrite, kindReadWait:
				begin
					access(rowKind[i] == kindWrite, rowReg[i], rowData[i], readBack, cycles,
						sawHold);
					if (rowKind[i] != kindWrite)
					begin
						checkCount++;
						if (readBack !== rowExpect[i])
							reportMismatch(rowName[i], rowExpect[i], readBack);
					end
					if (rowLatency[i] != 0)
					begin
						checkCount++;
						if (cycles != rowLatency[i])
							reportMismatch({rowName[i], " latency"}, rowLatency[i], cycles);
					end
					if (rowKind[i] == kindReadWait)
					begin
						checkCount++;
						if (!sawHold)
						begin
							errorCount++;
							$display("error: %s got OK without a HOLD during the transfer",
								rowName[i]);
						end
					end
				end
				kindWaitIdle:
				begin
					// poll CTRL until the busy bit clears
					readBack = '1;
					while (readBack[`SDSPI_CTRL_XMIT1])
						access(1'b0, regCtrl, '0, readBack, cycles, sawHold);
				end
				kindCs:
				begin
					@(negedge clock);
					checkCount++;
					if (spiCs !== rowExpect[i][0])
						reportMismatch(rowName[i], rowExpect[i], spiCs);
				end
				kindMosi:
				begin
					checkCount++;
					if (mosiCapture !== rowExpect[i])
						reportMismatch(rowName[i], rowExpect[i], mosiCapture);
				end
				kindPeriod:
				begin
					checkCount++;
					if (risePeriod != rowExpect[i])
						reportMismatch(rowName[i], rowExpect[i], risePeriod);
				end
			endcase
		end

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== SdSpiTop.f ====
+incdir+.
SdSpiPkg.sv
SdSpiDecode.sv
SdSpiEngine.sv
SdSpiResult.sv
SdSpiTop.sv
SdSpiTb.sv

// ==== Bender.yml ====
package:
  name: sdspi

sources:
  - include_dirs:
      - .
    files:
      - SdSpiPkg.sv
      - SdSpiDecode.sv
      - SdSpiEngine.sv
      - SdSpiResult.sv
      - SdSpiTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - SdSpiTb.sv
